/* src/rxGain_macros.svh */
`ifndef RXGAIN_MACROS_SVH
`define RXGAIN_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~

// input samples and gain output
`define SAMPLE_WIDTH 18
// integrate-and-dump accumulator
`define ACC_WIDTH 48
// gain exponent, 0..30 used, 31 behaves as 30
`define EXP_WIDTH 5
// mantissa fraction, gain factor is 1.mantissa
`define MANT_WIDTH 16

// ~~~~~~~~~~~~~~~~~~~~
// register block
// ~~~~~~~~~~~~~~~~~~~~

`define DUMP_WIDTH 16
`define REG_ADDR_WIDTH 4
`define REG_DATA_WIDTH 32
`define DEFAULT_DUMP_LENGTH 4

`endif

/* src/dspTypesPkg.sv */
`include "rxGain_macros.svh"

package dspTypesPkg;

    // one sample on the stream, valid is a single-cycle strobe
    typedef struct packed {
        logic                             valid;
        logic signed [`SAMPLE_WIDTH-1:0]  data;
    } sample_t;

    // completed integrate-and-dump sum
    typedef struct packed {
        logic                             valid;
        logic signed [`ACC_WIDTH-1:0]     sum;
    } dumpResult_t;

    // gain = 2^(exponent-30) * (1 + mantissa/65536)
    typedef struct packed {
        logic [`EXP_WIDTH-1:0]            exponent;
        logic [`MANT_WIDTH-1:0]           mantissa;
    } gainSetting_t;

endpackage

/* src/regMapPkg.sv */
`include "rxGain_macros.svh"

package regMapPkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // register addresses
    // ~~~~~~~~~~~~~~~~~~~~

    localparam logic [`REG_ADDR_WIDTH-1:0] GAIN_ADDR = `REG_ADDR_WIDTH'(0);
    localparam logic [`REG_ADDR_WIDTH-1:0] DUMP_ADDR = `REG_ADDR_WIDTH'(1);

    // ~~~~~~~~~~~~~~~~~~~~
    // write data layouts
    // ~~~~~~~~~~~~~~~~~~~~

    // gain register, exponent above mantissa in the low bits
    typedef struct packed {
        logic [`REG_DATA_WIDTH-`EXP_WIDTH-`MANT_WIDTH-1:0] pad;
        logic [`EXP_WIDTH-1:0]                              exponent;
        logic [`MANT_WIDTH-1:0]                             mantissa;
    } gainView_t;

    // dump length register
    typedef struct packed {
        logic [`REG_DATA_WIDTH-`DUMP_WIDTH-1:0]             pad;
        logic [`DUMP_WIDTH-1:0]                             dumpLength;
    } dumpView_t;

    // same write word, read through whichever view the address selects
    typedef union packed {
        gainView_t gainView;
        dumpView_t dumpView;
    } regWord_u;

endpackage

/* src/gainRegisters.sv */
`include "rxGain_macros.svh"

module gainRegisters (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        wrEn,
    input  logic [`REG_ADDR_WIDTH-1:0]  wrAddr,
    input  regMapPkg::regWord_u         wrData,
    output dspTypesPkg::gainSetting_t   gain,
    output logic [`DUMP_WIDTH-1:0]      dumpLength
);

    import regMapPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // gain register
    // ~~~~~~~~~~~~~~~~~~~~

    // exponent and mantissa both come out of reset at zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            gain <= '0;
        end else if (wrEn && (wrAddr == GAIN_ADDR)) begin
            gain.exponent <= wrData.gainView.exponent;
            gain.mantissa <= wrData.gainView.mantissa;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // dump length register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dumpLength <= `DUMP_WIDTH'(`DEFAULT_DUMP_LENGTH);
        end else if (wrEn && (wrAddr == DUMP_ADDR)) begin
            dumpLength <= wrData.dumpView.dumpLength;
        end
    end

    // writes to any other address fall through both decoders

endmodule

/* src/integrateDump.sv */
`include "rxGain_macros.svh"

module integrateDump (
    input  logic                        clk,
    input  logic                        rstN,
    input  dspTypesPkg::sample_t        sampleIn,
    input  logic [`DUMP_WIDTH-1:0]      dumpLength,
    output dspTypesPkg::dumpResult_t    sumOut
);

    logic [`DUMP_WIDTH-1:0]         sampleCount;
    logic [`DUMP_WIDTH-1:0]         lastIndex;
    logic signed [`ACC_WIDTH-1:0]   accum;
    logic signed [`ACC_WIDTH-1:0]   sampleExt;
    logic signed [`ACC_WIDTH-1:0]   accumNext;
    logic signed [`ACC_WIDTH-1:0]   sumData;
    logic                           sumValid;
    logic signed [`ACC_WIDTH-1:0]   outSum;
    logic                           outValid;
    logic                           dumpNow;

    // length 0 is treated as length 1
    assign lastIndex = (dumpLength == '0) ? '0 : dumpLength - 1'b1;

    assign sampleExt = {{(`ACC_WIDTH-`SAMPLE_WIDTH){sampleIn.data[`SAMPLE_WIDTH-1]}},
                        sampleIn.data};
    assign accumNext = accum + sampleExt;

    // >= so that shrinking the length mid-dump still ends the period
    assign dumpNow = sampleIn.valid && (sampleCount >= lastIndex);

    // ~~~~~~~~~~~~~~~~~~~~
    // counter and accumulator
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleCount <= '0;
            accum       <= '0;
            sumValid    <= 1'b0;
        end else begin
            sumValid <= dumpNow;
            if (dumpNow) begin
                // restart empty, the next sample begins a fresh sum
                sampleCount <= '0;
                accum       <= '0;
            end else if (sampleIn.valid) begin
                sampleCount <= sampleCount + 1'b1;
                accum       <= accumNext;
            end
        end
    end

    // completed sum includes the sample accepted on the dump edge
    always_ff @(posedge clk) begin
        if (dumpNow) begin
            sumData <= accumNext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~

    // sum leaves one cycle after the dump edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sumValid;
        end
    end

    always_ff @(posedge clk) begin
        outSum <= sumData;
    end

    assign sumOut.valid = outValid;
    assign sumOut.sum   = outSum;

endmodule

/* src/variableGain.sv */
`include "rxGain_macros.svh"

module variableGain (
    input  logic                        clk,
    input  logic                        rstN,
    input  dspTypesPkg::dumpResult_t    sumIn,
    input  dspTypesPkg::gainSetting_t   gain,
    output dspTypesPkg::sample_t        gainOut
);

    // exponent 30 selects the low 18 bits of the sum unshifted
    localparam int maxShift  = `ACC_WIDTH - `SAMPLE_WIDTH;
    localparam int prodWidth = 2 * `SAMPLE_WIDTH;
    localparam int prodTop   = prodWidth - `MANT_WIDTH - `SAMPLE_WIDTH + 1;

    // symmetric limits, +131071 and -131071
    localparam logic signed [`SAMPLE_WIDTH-1:0] satHigh =
        {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
    localparam logic signed [`SAMPLE_WIDTH-1:0] satLow =
        {1'b1, {(`SAMPLE_WIDTH-2){1'b0}}, 1'b1};

    logic [`EXP_WIDTH-1:0]              expClamped;
    logic [`EXP_WIDTH-1:0]              shiftAmt;
    logic signed [`ACC_WIDTH-1:0]       shifted;
    logic                               sumSign;
    logic [maxShift-1:0]                highBits;

    logic                               s1Valid;
    logic                               s1SatPos;
    logic                               s1SatNeg;
    logic [`SAMPLE_WIDTH-1:0]           s1Window;
    logic [`MANT_WIDTH-1:0]             s1Mant;

    logic                               s2Valid;
    logic signed [`SAMPLE_WIDTH-1:0]    s2Shift;
    logic [`MANT_WIDTH-1:0]             s2Mant;

    logic                               s3Valid;
    logic signed [prodWidth-1:0]        s3Product;
    logic [prodTop-1:0]                 prodHigh;

    logic                               outValid;
    logic signed [`SAMPLE_WIDTH-1:0]    outData;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 1, window select
    // ~~~~~~~~~~~~~~~~~~~~

    assign expClamped = (gain.exponent > maxShift) ? `EXP_WIDTH'(maxShift) : gain.exponent;
    assign shiftAmt   = `EXP_WIDTH'(maxShift) - expClamped;
    assign shifted    = $signed(sumIn.sum) >>> shiftAmt;
    assign sumSign    = sumIn.sum[`ACC_WIDTH-1];

    // bits above the window must all match the sign for the value to fit
    assign highBits = shifted[`ACC_WIDTH-2:`SAMPLE_WIDTH-1];

    always_ff @(posedge clk) begin
        s1SatPos <= !sumSign && (highBits != '0);
        s1SatNeg <= sumSign && (highBits != '1);
        s1Window <= shifted[`SAMPLE_WIDTH-1:0];
        // mantissa travels with its sum from here on
        s1Mant   <= gain.mantissa;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 2, shift saturation
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (s1SatPos) begin
            s2Shift <= satHigh;
        end else if (s1SatNeg) begin
            s2Shift <= satLow;
        end else begin
            s2Shift <= s1Window;
        end
        s2Mant <= s1Mant;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 3, 18x18 multiply
    // ~~~~~~~~~~~~~~~~~~~~

    // multiplicand is 1.mantissa, always positive
    always_ff @(posedge clk) begin
        s3Product <= s2Shift * $signed({{(`SAMPLE_WIDTH-`MANT_WIDTH-1){1'b0}}, 1'b1, s2Mant});
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stage 4, output saturation
    // ~~~~~~~~~~~~~~~~~~~~

    assign prodHigh = s3Product[prodWidth-1:`MANT_WIDTH+`SAMPLE_WIDTH-1];

    always_ff @(posedge clk) begin
        if ((prodHigh == '0) || (prodHigh == '1)) begin
            outData <= s3Product[`MANT_WIDTH+`SAMPLE_WIDTH-1:`MANT_WIDTH];
        end else begin
            outData <= s3Product[prodWidth-1] ? satLow : satHigh;
        end
    end

    // valid pipeline, four stages deep
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid  <= 1'b0;
            s2Valid  <= 1'b0;
            s3Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            s1Valid  <= sumIn.valid;
            s2Valid  <= s1Valid;
            s3Valid  <= s2Valid;
            outValid <= s3Valid;
        end
    end

    assign gainOut.valid = outValid;
    assign gainOut.data  = outData;

endmodule

/* src/rxGainChain.sv */
`include "rxGain_macros.svh"

module rxGainChain (
    input  logic                        clk,
    input  logic                        rstN,
    input  dspTypesPkg::sample_t        sampleIn,
    input  logic                        wrEn,
    input  logic [`REG_ADDR_WIDTH-1:0]  wrAddr,
    input  regMapPkg::regWord_u         wrData,
    output dspTypesPkg::sample_t        gainOut
);

    import dspTypesPkg::*;

    gainSetting_t               gain;
    logic [`DUMP_WIDTH-1:0]     dumpLength;
    dumpResult_t                sumOut;

    // ~~~~~~~~~~~~~~~~~~~~
    // control registers
    // ~~~~~~~~~~~~~~~~~~~~

    gainRegisters regs (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .gain       (gain),
        .dumpLength (dumpLength)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~

    integrateDump decimator (
        .clk        (clk),
        .rstN       (rstN),
        .sampleIn   (sampleIn),
        .dumpLength (dumpLength),
        .sumOut     (sumOut)
    );

    // sum to output is 4 cycles, sample to output is 5
    variableGain scaler (
        .clk        (clk),
        .rstN       (rstN),
        .sumIn      (sumOut),
        .gain       (gain),
        .gainOut    (gainOut)
    );

endmodule

/* verification/rxGainChain_properties.sv */
`include "rxGain_macros.svh"

module rxGainChain_properties (
    input logic                             clk,
    input logic                             rstN,
    input dspTypesPkg::dumpResult_t         sumOut,
    input dspTypesPkg::sample_t             gainOut,
    input logic [2*`SAMPLE_WIDTH-1:0]       product
);
    timeunit 1ns;
    timeprecision 1ps;

    logic productFit;

    // top three product bits agree when the shifted-down result fits 18 bits
    assign productFit = (product[2*`SAMPLE_WIDTH-1:`MANT_WIDTH+`SAMPLE_WIDTH-1] == '0)
                     || (product[2*`SAMPLE_WIDTH-1:`MANT_WIDTH+`SAMPLE_WIDTH-1] == '1);

    // ~~~~~~~~~~~~~~~~~~~~
    // strobes
    // ~~~~~~~~~~~~~~~~~~~~

    resetClearsValids: assert property (@(posedge clk)
        (!rstN && $past(!rstN)) |-> (!sumOut.valid && !gainOut.valid))
        else $error("valid strobe high while reset is held");

    sumToGainLatency: assert property (@(posedge clk) disable iff (!rstN)
        sumOut.valid |-> ##4 gainOut.valid)
        else $error("gainOut.valid missing 4 cycles after sumOut.valid");

    gainHasSource: assert property (@(posedge clk) disable iff (!rstN)
        gainOut.valid |-> $past(sumOut.valid, 4))
        else $error("gainOut.valid without a sum 4 cycles earlier");

    // the saturated negative limit is -131071, so -131072 only comes from a clean product
    negativeFullScale: assert property (@(posedge clk) disable iff (!rstN)
        (gainOut.valid && (gainOut.data == 18'sh20000)) |-> $past(productFit))
        else $error("gainOut.data is -131072 after a saturated product");

endmodule

bind rxGainChain rxGainChain_properties props (
    .clk     (clk),
    .rstN    (rstN),
    .sumOut  (sumOut),
    .gainOut (gainOut),
    .product (scaler.s3Product)
);

/* verification/rxGainChainTb.sv */
`include "rxGain_macros.svh"

module rxGainChainTb;
    timeunit 1ns;
    timeprecision 1ps;

    import dspTypesPkg::*;
    import regMapPkg::*;

    localparam int satMax = 131071;

    logic                        clk;
    logic                        rstN;
    sample_t                     sampleIn;
    logic                        wrEn;
    logic [`REG_ADDR_WIDTH-1:0]  wrAddr;
    regWord_u                    wrData;
    sample_t                     gainOut;

    int          expected[$];
    longint      refAcc;
    int          refCount;
    int          refLength;
    int          refExp;
    int          refMant;
    logic [15:0] lfsrState;
    int          errors;
    int          checks;
    int          outputs;
    int          cycleCount;
    int          acceptCycle;
    int          outCycle;

    rxGainChain dut (
        .clk      (clk),
        .rstN     (rstN),
        .sampleIn (sampleIn),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .gainOut  (gainOut)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            bits      = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic int randomSample();
        logic [31:0] bits;
        bits = randomBits(`SAMPLE_WIDTH);
        return int'($signed(bits[`SAMPLE_WIDTH-1:0]));
    endfunction

    // window shift with symmetric clamp, then 1.mantissa with symmetric clamp
    function automatic int scaledValue(input longint sum, input int exponent, input int mant);
        longint shifted;
        longint product;
        int     k;
        k       = (exponent > 30) ? 30 : exponent;
        shifted = sum >>> (30 - k);
        if (shifted > satMax) begin
            shifted = satMax;
        end else if (shifted < -satMax - 1) begin
            shifted = -satMax;
        end
        product = (shifted * (65536 + mant)) >>> 16;
        if (product > satMax) begin
            return satMax;
        end else if (product < -satMax - 1) begin
            return -satMax;
        end
        return int'(product);
    endfunction

    function automatic void predictSample(input int value);
        refAcc   += value;
        refCount += 1;
        if (refCount >= ((refLength == 0) ? 1 : refLength)) begin
            expected.push_back(scaledValue(refAcc, refExp, refMant));
            refAcc   = 0;
            refCount = 0;
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // drivers and monitor
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic driveCycle(input logic valid, input int value);
        @(posedge clk);
        #2;
        wrEn           = 1'b0;
        sampleIn.valid = valid;
        sampleIn.data  = `SAMPLE_WIDTH'(value);
        if (valid) begin
            acceptCycle = cycleCount + 1;
            predictSample(value);
        end
    endtask

    task automatic writeReg(input logic [`REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        sampleIn.valid = 1'b0;
        wrEn           = 1'b1;
        wrAddr         = addr;
        wrData         = data;
        // gain word is exponent in 20:16 and mantissa in 15:0
        if (addr == GAIN_ADDR) begin
            refExp  = int'(data[20:16]);
            refMant = int'(data[15:0]);
        end else if (addr == DUMP_ADDR) begin
            refLength = int'(data[15:0]);
        end
    endtask

    task automatic setGain(input int exponent, input int mant);
        regWord_u word;
        word                   = '0;
        word.gainView.exponent = `EXP_WIDTH'(exponent);
        word.gainView.mantissa = `MANT_WIDTH'(mant);
        writeReg(GAIN_ADDR, word);
    endtask

    task automatic setLength(input int length);
        regWord_u word;
        word                     = '0;
        word.dumpView.dumpLength = `DUMP_WIDTH'(length);
        writeReg(DUMP_ADDR, word);
    endtask

    task automatic sendRandom(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            if (gaps && (randomBits(1) != 0)) begin
                driveCycle(1'b0, 0);
            end
            driveCycle(1'b1, randomSample());
        end
        driveCycle(1'b0, 0);
    endtask

    task automatic waitDrain(input int limit);
        int n;
        n = 0;
        while ((expected.size() != 0) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (expected.size() != 0) begin
            $display("timeout: %0d predicted outputs never appeared", expected.size());
            $display("TEST FAIL");
            $finish;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("[%0t] %s finished, %0d new errors", $time, name, errors - errBefore);
    endtask

    always @(negedge clk) begin
        int want;
        if (rstN && gainOut.valid) begin
            outCycle = cycleCount;
            outputs++;
            assert (expected.size() != 0) else begin
                $display("error at %0t: gainOut.valid with no output predicted", $time);
                errors++;
            end
            if (expected.size() != 0) begin
                want = expected.pop_front();
                checks++;
                assert (int'(gainOut.data) == want) else begin
                    $display("[FAIL] %0t gainOut.data got %0d expected %0d",
                             $time, gainOut.data, want);
                    errors++;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic testReset();
        int errBefore;
        errBefore = errors;
        repeat (20) driveCycle(1'b0, 0);
        checks++;
        assert (outputs == 0) else begin
            $display("error: gainOut.valid rose after reset with no samples sent");
            errors++;
        end
        // default length 4, exponent 0
        sendRandom(4, 1'b0);
        waitDrain(40);
        checks++;
        assert (outCycle - acceptCycle == 5) else begin
            $display("[FAIL] %0t gainOut.valid latency got %0d expected %0d",
                     $time, outCycle - acceptCycle, 5);
            errors++;
        end
        reportTest("reset", errBefore);
    endtask

    task automatic testUnity();
        int errBefore;
        errBefore = errors;
        setLength(1);
        setGain(30, 0);
        sendRandom(24, 1'b0);
        sendRandom(16, 1'b1);
        waitDrain(60);
        reportTest("unity", errBefore);
    endtask

    task automatic testIntegration();
        int errBefore;
        errBefore = errors;
        setLength(3);
        setGain(29, 0);
        sendRandom(30, 1'b1);
        setLength(16);
        setGain(26, 0);
        sendRandom(48, 1'b1);
        waitDrain(60);
        reportTest("integration", errBefore);
    endtask

    task automatic testShiftSaturation();
        int errBefore;
        errBefore = errors;
        setLength(8);
        setGain(28, 0);
        repeat (8) driveCycle(1'b1, 120000);
        repeat (8) driveCycle(1'b1, -120000);
        driveCycle(1'b0, 0);
        // sum of -131072 x 8 lands exactly on the negative limit of the window
        setGain(27, 0);
        repeat (8) driveCycle(1'b1, -131072);
        repeat (8) driveCycle(1'b1, 130000);
        driveCycle(1'b0, 0);
        waitDrain(60);
        reportTest("shift saturation", errBefore);
    endtask

    task automatic testMantissa();
        int errBefore;
        errBefore = errors;
        setLength(1);
        setGain(30, 'h8000);
        sendRandom(16, 1'b0);
        setGain(30, 'hFFFF);
        sendRandom(16, 1'b1);
        driveCycle(1'b1, 70000);
        driveCycle(1'b1, -70000);
        driveCycle(1'b1, 131071);
        driveCycle(1'b1, -131072);
        driveCycle(1'b0, 0);
        waitDrain(60);
        reportTest("mantissa", errBefore);
    endtask

    task automatic testGainInFlight();
        int errBefore;
        errBefore = errors;
        setLength(2);
        setGain(30, 0);
        repeat (6) driveCycle(1'b1, randomSample());
        driveCycle(1'b0, 0);
        // two sums still in the pipeline here
        setGain(29, 'h4000);
        writeReg(`REG_ADDR_WIDTH'(7), '1);
        repeat (6) driveCycle(1'b1, randomSample());
        driveCycle(1'b0, 0);
        waitDrain(60);
        reportTest("gain in flight", errBefore);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        sampleIn   = '0;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        lfsrState  = 16'd75;
        refAcc     = 0;
        refCount   = 0;
        refLength  = `DEFAULT_DUMP_LENGTH;
        refExp     = 0;
        refMant    = 0;
        errors     = 0;
        checks     = 0;
        outputs    = 0;
        cycleCount = 0;
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;
        testReset();
        testUnity();
        testIntegration();
        testShiftSaturation();
        testMantissa();
        testGainInFlight();
        $display("6 tests, %0d outputs, %0d checks, %0d errors", outputs, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rxGainChain.f */
+incdir+src
src/dspTypesPkg.sv
src/regMapPkg.sv
src/gainRegisters.sv
src/integrateDump.sv
src/variableGain.sv
src/rxGainChain.sv
verification/rxGainChain_properties.sv
verification/rxGainChainTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= rxGainChainTb
FILELIST  ?= rxGainChain.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
